// File: design/aes_lin_params.svh
// bus widths, register map and control bit positions
// of the AES linear round engine
`ifndef AES_LIN_PARAMS_SVH
`define AES_LIN_PARAMS_SVH

// AXI4-Lite sizes
`define AES_ADDR_W 6
`define AES_DATA_W 32

// register offsets, bytes
`define AES_REG_STATE0 6'h00
`define AES_REG_KEY0 6'h10
`define AES_REG_CTRL 6'h20
`define AES_REG_STATUS 6'h24

// command word bits
`define AES_CTRL_START 0
`define AES_CTRL_DECRYPT 1
`define AES_CTRL_LAST 2

// status word bits
`define AES_STAT_BUSY 0
`define AES_STAT_DONE 1

// cycles from start acceptance to busy falling
`define AES_PASS_CYCLES 6

`endif

// File: design/aes_lin_pkg.sv
// shared types of the AES linear round engine
// column word union and cipher direction
`default_nettype none

package aes_lin_pkg;

	//////////////////////////////////////////////////
	// one state column, seen as a word or as bytes
	//////////////////////////////////////////////////
	typedef union packed
	{
		logic [31:0] word; // bus and register view
		logic [3:0][7:0] bytes; // bytes[r] holds row r, row 0 in low bits
	} col_word_u;

	// direction of the round, value matches the decrypt bit of the command
	typedef enum logic
	{
		MODE_ENC = 1'b0, // ShiftRows, MixColumns, AddRoundKey
		MODE_DEC = 1'b1 // InvShiftRows, AddRoundKey, InvMixColumns
	} aes_mode_e;

endpackage

`default_nettype wire

// File: design/state_shift_rows.sv
// ShiftRows and InvShiftRows on the full 128-bit state
// row r rotates left by r columns for encrypt, right for decrypt
`timescale 1ns/1ns
`default_nettype none

module state_shift_rows
	import aes_lin_pkg::*;
(
	input wire [127:0] state,
	input wire aes_mode_e mode,
	output logic [127:0] shifted
);

	col_word_u in_cols [4];
	col_word_u out_cols [4];

	always_comb
	begin
		for (int c = 0; c < 4; c++)
			in_cols[c].word = state[32*c +: 32]; // column 0 in low word
	end

	always_comb
	begin
		for (int c = 0; c < 4; c++)
		begin
			for (int r = 0; r < 4; r++)
			begin
				if (mode == MODE_ENC)
					out_cols[c].bytes[r] = in_cols[(c + r) % 4].bytes[r]; // left by r
				else
					out_cols[c].bytes[r] = in_cols[(c + 4 - r) % 4].bytes[r]; // right by r
			end
		end
	end

	always_comb
	begin
		for (int c = 0; c < 4; c++)
			shifted[32*c +: 32] = out_cols[c].word;
	end

endmodule

`default_nettype wire

// File: design/word_mix_columns.sv
// MixColumns and InvMixColumns on one column per cycle
// GF(2^8) products from chained doubling, poly 0x11b
// result and done registered one cycle after ready
`timescale 1ns/1ns
`default_nettype none

module word_mix_columns
	import aes_lin_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire col_word_u col_in,
	input wire ready,
	input wire encrypt,
	output col_word_u col_out,
	output logic done
);

	logic [7:0] x1 [4], x2 [4], x4 [4], x8 [4]; // doubling chain per row
	logic [7:0] m3 [4], m9 [4], m11 [4], m13 [4], m14 [4];
	col_word_u mixed;

	// multiply by x, reduce by 0x1b on carry out
	function automatic logic [7:0] xtime(input logic [7:0] a);
		return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
	endfunction

	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			x1[i] = col_in.bytes[i];
			x2[i] = xtime(x1[i]);
			x4[i] = xtime(x2[i]);
			x8[i] = xtime(x4[i]);
			m3[i] = x2[i] ^ x1[i];
			m9[i] = x8[i] ^ x1[i];
			m11[i] = x8[i] ^ x2[i] ^ x1[i];
			m13[i] = x8[i] ^ x4[i] ^ x1[i];
			m14[i] = x8[i] ^ x4[i] ^ x2[i];
		end
	end

	// circulant rows {2,3,1,1} and {14,11,13,9}
	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (encrypt)
				mixed.bytes[i] = x2[i] ^ m3[(i + 1) % 4] ^ x1[(i + 2) % 4] ^ x1[(i + 3) % 4];
			else
				mixed.bytes[i] = m14[i] ^ m11[(i + 1) % 4] ^ m13[(i + 2) % 4] ^ m9[(i + 3) % 4];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			done <= 1'b0;
		else
			done <= ready; // single cycle strobe per issue
	end

	always_ff @(posedge clk)
	begin
		if (ready)
			col_out <= mixed;
	end

endmodule

`default_nettype wire

// File: design/state_store.sv
// four state column registers
// byte strobed bus writes, whole state shifted load
// round key addition and per column writeback
`timescale 1ns/1ns
`default_nettype none

module state_store
	import aes_lin_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire wr_en,
	input wire [1:0] wr_idx,
	input wire [31:0] wr_data,
	input wire [3:0] wr_strb,
	input wire [1:0] rd_idx,
	input wire [1:0] col_sel,
	input wire load_shifted,
	input wire [127:0] shifted,
	input wire wb_en,
	input wire aes_mode_e mode,
	input wire last,
	input wire col_word_u key_word,
	input wire col_word_u mix_out,
	input wire wb_sel,
	output logic [127:0] state,
	output col_word_u rd_word,
	output col_word_u mix_in
);

	col_word_u st_q [4];
	logic [1:0] wb_idx; // column issued last cycle
	col_word_u wb_key; // its round key word
	col_word_u wb_val;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int c = 0; c < 4; c++)
				st_q[c] <= '0;
			wb_idx <= 2'd0;
		end
		else
		begin
			wb_idx <= col_sel; // tracks the mixer pipeline stage
			if (load_shifted)
			begin
				for (int c = 0; c < 4; c++)
					st_q[c].word <= shifted[32*c +: 32];
			end
			else if (wb_en)
				st_q[wb_idx] <= wb_val;
			else if (wr_en)
			begin
				for (int b = 0; b < 4; b++)
					if (wr_strb[b])
						st_q[wr_idx].bytes[b] <= wr_data[8*b +: 8];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		wb_key <= key_word;
	end

	// decrypt adds the key before InvMixColumns
	assign mix_in.word = (mode == MODE_DEC) ? (st_q[col_sel].word ^ key_word.word)
		: st_q[col_sel].word;

	always_comb
	begin
		if (wb_sel && !last)
			wb_val.word = (mode == MODE_ENC) ? (mix_out.word ^ wb_key.word) : mix_out.word;
		else
			wb_val.word = st_q[wb_idx].word ^ wb_key.word; // last round bypass
	end

	assign rd_word = st_q[rd_idx];
	assign state = {st_q[3].word, st_q[2].word, st_q[1].word, st_q[0].word};

endmodule

`default_nettype wire

// File: design/aes_lin_ctrl.sv
// AXI4-Lite slave of the AES linear round engine
// key words, command bits, status flags
// six cycle round sequencer driving shift load, column issue, writeback
`timescale 1ns/1ns
`default_nettype none
`include "aes_lin_params.svh"

module aes_lin_ctrl
	import aes_lin_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire [`AES_ADDR_W-1:0] awaddr,
	input wire awvalid,
	output logic awready,
	input wire [`AES_DATA_W-1:0] wdata,
	input wire [`AES_DATA_W/8-1:0] wstrb,
	input wire wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire bready,
	input wire [`AES_ADDR_W-1:0] araddr,
	input wire arvalid,
	output logic arready,
	output logic [`AES_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire rready,
	input wire col_word_u state_rd_word,
	input wire mix_done,
	output logic st_wr_en,
	output logic [1:0] st_wr_idx,
	output logic [`AES_DATA_W-1:0] st_wr_data,
	output logic [`AES_DATA_W/8-1:0] st_wr_strb,
	output logic [1:0] rd_idx,
	output logic [1:0] col_sel,
	output logic load_shifted,
	output logic wb_en,
	output aes_mode_e mode,
	output logic last,
	output col_word_u key_word,
	output logic mix_ready,
	output logic busy
);

	logic wr_fire, ar_fire; // bus handshakes
	logic is_state_w, is_key_w, is_ctrl_w; // write decode
	logic start_go; // accepted start while idle
	logic [2:0] cnt; // run cycle, 0 to 5
	logic issue, wb_phase;
	logic run_done; // sticky until next start
	col_word_u key_q [4];
	logic [`AES_DATA_W-1:0] rd_mux;

	//////////////////////////////////////////////////
	// write channel
	//////////////////////////////////////////////////
	assign awready = awvalid & wvalid & ~bvalid; // addr and data taken together
	assign wready = awvalid & wvalid & ~bvalid;
	assign wr_fire = awvalid & awready & wvalid & wready;
	assign bresp = 2'b00; // always OKAY

	assign is_state_w = ({awaddr[5:4], 4'h0} == `AES_REG_STATE0);
	assign is_key_w = ({awaddr[5:4], 4'h0} == `AES_REG_KEY0);
	assign is_ctrl_w = ({awaddr[5:2], 2'b00} == `AES_REG_CTRL);
	assign start_go = wr_fire & is_ctrl_w & wstrb[0] & wdata[`AES_CTRL_START] & ~busy;

	// state words live in the store, writes are dropped while running
	assign st_wr_en = wr_fire & is_state_w & ~busy;
	assign st_wr_idx = awaddr[3:2];
	assign st_wr_data = wdata;
	assign st_wr_strb = wstrb;

	always_ff @(posedge clk)
	begin
		if (reset)
			bvalid <= 1'b0;
		else if (wr_fire)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0; // held until taken
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 4; i++)
				key_q[i] <= '0;
			mode <= MODE_ENC;
			last <= 1'b0;
		end
		else if (wr_fire && !busy)
		begin
			if (is_key_w)
			begin
				for (int b = 0; b < 4; b++)
					if (wstrb[b])
						key_q[awaddr[3:2]].bytes[b] <= wdata[8*b +: 8]; // per byte strobe
			end
			if (is_ctrl_w && wstrb[0]) // command uses byte 0 only
			begin
				mode <= aes_mode_e'(wdata[`AES_CTRL_DECRYPT]);
				last <= wdata[`AES_CTRL_LAST];
			end
		end
	end

	//////////////////////////////////////////////////
	// read channel
	//////////////////////////////////////////////////
	assign arready = ~rvalid; // one read in flight
	assign ar_fire = arvalid & arready;
	assign rresp = 2'b00;
	assign rd_idx = araddr[3:2]; // store presents this word

	always_comb
	begin
		rd_mux = '0;
		case ({araddr[5:4], 4'h0})
			`AES_REG_STATE0: rd_mux = state_rd_word.word;
			`AES_REG_KEY0: rd_mux = key_q[araddr[3:2]].word;
			default:
			begin
				if ({araddr[5:2], 2'b00} == `AES_REG_CTRL)
				begin
					rd_mux[`AES_CTRL_DECRYPT] = (mode == MODE_DEC); // start reads as 0
					rd_mux[`AES_CTRL_LAST] = last;
				end
				else if ({araddr[5:2], 2'b00} == `AES_REG_STATUS)
				begin
					rd_mux[`AES_STAT_BUSY] = busy;
					rd_mux[`AES_STAT_DONE] = run_done;
				end
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			rvalid <= 1'b0;
		else if (ar_fire)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (ar_fire)
			rdata <= rd_mux; // stable while rvalid waits
	end

	//////////////////////////////////////////////////
	// round sequencer
	//////////////////////////////////////////////////
	// cnt 0 loads shifted state, 1..4 issue columns, 2..5 write back
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			run_done <= 1'b0;
			cnt <= 3'd0;
		end
		else if (start_go)
		begin
			busy <= 1'b1; // up the cycle after acceptance
			run_done <= 1'b0;
			cnt <= 3'd0;
		end
		else if (busy)
		begin
			cnt <= cnt + 3'd1;
			if (cnt == 3'(`AES_PASS_CYCLES - 1))
			begin
				busy <= 1'b0; // last writeback edge
				run_done <= 1'b1;
			end
		end
	end

	assign load_shifted = busy && (cnt == 3'd0);
	assign issue = busy && (cnt >= 3'd1) && (cnt <= 3'd4);
	assign wb_phase = busy && (cnt >= 3'd2) && (cnt <= 3'd5); // one behind issue
	assign col_sel = 2'(cnt - 3'd1);
	assign key_word = key_q[col_sel];
	assign mix_ready = issue & ~last; // mixer skipped on last round
	assign wb_en = wb_phase & (last | mix_done);

endmodule

`default_nettype wire

// File: design/aes_lin_top.sv
// top level of the AES linear round engine
// AXI4-Lite controller, ShiftRows, column mixer, state store
`timescale 1ns/1ns
`default_nettype none
`include "aes_lin_params.svh"

module aes_lin_top
	import aes_lin_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire [`AES_ADDR_W-1:0] awaddr,
	input wire awvalid,
	output logic awready,
	input wire [`AES_DATA_W-1:0] wdata,
	input wire [`AES_DATA_W/8-1:0] wstrb,
	input wire wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire bready,
	input wire [`AES_ADDR_W-1:0] araddr,
	input wire arvalid,
	output logic arready,
	output logic [`AES_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire rready
);

	logic st_wr_en;
	logic [1:0] st_wr_idx, rd_idx, col_sel;
	logic [`AES_DATA_W-1:0] st_wr_data;
	logic [`AES_DATA_W/8-1:0] st_wr_strb;
	logic load_shifted, wb_en, last, mix_ready, mix_done;
	aes_mode_e mode;
	col_word_u key_word, state_rd_word, mix_in, mix_out;
	logic [127:0] state, shifted;

	aes_lin_ctrl u_ctrl (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.state_rd_word(state_rd_word), .mix_done(mix_done),
		.st_wr_en(st_wr_en), .st_wr_idx(st_wr_idx),
		.st_wr_data(st_wr_data), .st_wr_strb(st_wr_strb),
		.rd_idx(rd_idx), .col_sel(col_sel), .load_shifted(load_shifted),
		.wb_en(wb_en), .mode(mode), .last(last), .key_word(key_word),
		.mix_ready(mix_ready),
		.busy() // status register and checker only
	);

	state_shift_rows u_shift (
		.state(state), .mode(mode), .shifted(shifted)
	);

	word_mix_columns u_mix (
		.clk(clk), .reset(reset),
		.col_in(mix_in), .ready(mix_ready), .encrypt(mode == MODE_ENC),
		.col_out(mix_out), .done(mix_done)
	);

	state_store u_store (
		.clk(clk), .reset(reset),
		.wr_en(st_wr_en), .wr_idx(st_wr_idx), .wr_data(st_wr_data), .wr_strb(st_wr_strb),
		.rd_idx(rd_idx), .col_sel(col_sel), .load_shifted(load_shifted),
		.shifted(shifted), .wb_en(wb_en), .mode(mode), .last(last),
		.key_word(key_word), .mix_out(mix_out),
		.wb_sel(mix_done), // mixer result valid this cycle
		.state(state), .rd_word(state_rd_word), .mix_in(mix_in)
	);

endmodule

`default_nettype wire

// File: sim/aes_lin_chk.sv
// bound assertions for the AES controller
// AXI4-Lite response holding, run length, mixer issue while idle
`timescale 1ns/1ns
`default_nettype none
`include "aes_lin_params.svh"

module aes_lin_chk
(
	input wire clk,
	input wire reset,
	input wire bvalid,
	input wire bready,
	input wire rvalid,
	input wire rready,
	input wire [`AES_DATA_W-1:0] rdata,
	input wire busy,
	input wire mix_ready,
	input wire start_go
);

	int err_count = 0; // failed assertion tally, polled by the testbench

	//////////////////////////////////////////////////
	// bus responses
	//////////////////////////////////////////////////
	bvalid_hold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid)
	else
	begin
		err_count++;
		$error("bvalid dropped before bready");
	end

	rvalid_hold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata)) // data frozen too
	else
	begin
		err_count++;
		$error("rvalid or rdata changed before rready");
	end

	//////////////////////////////////////////////////
	// sequencer
	//////////////////////////////////////////////////
	run_length: assert property (@(posedge clk) disable iff (reset)
		start_go |=> busy [*`AES_PASS_CYCLES] ##1 !busy)
	else
	begin
		err_count++;
		$error("busy did not fall exactly at the end of the run");
	end

	// columns go out 2 to 5 cycles after the start edge
	idle_no_issue: assert property (@(posedge clk) disable iff (reset)
		mix_ready |-> $past(start_go, 2) || $past(start_go, 3) || $past(start_go, 4)
			|| $past(start_go, 5))
	else
	begin
		err_count++;
		$error("mixer issued while idle");
	end

endmodule

bind aes_lin_ctrl aes_lin_chk u_chk (
	.clk(clk),
	.reset(reset),
	.bvalid(bvalid),
	.bready(bready),
	.rvalid(rvalid),
	.rready(rready),
	.rdata(rdata),
	.busy(busy),
	.mix_ready(mix_ready),
	.start_go(start_go)
);

`default_nettype wire

// File: sim/aes_lin_tb.sv
// testbench of the AES linear round engine
// AXI4-Lite bus tasks with random response stalls
// reference round model built on GF(2^8) doubling
// readback checks, status timing, cycle timeout
`timescale 1ns/1ns
`default_nettype none
`include "aes_lin_params.svh"

module aes_lin_tb;

	localparam int RUN_CYCLES = 64; // operand writes, status polls, readback
	localparam int NUM_RUNS = 28; // 22 rounds plus the register tests
	localparam int TIMEOUT_CYCLES = NUM_RUNS * RUN_CYCLES + 200;
	localparam logic [3:0][3:0] FWD_COEF = {4'd1, 4'd1, 4'd3, 4'd2}; // {2,3,1,1}, entry 0 low
	localparam logic [3:0][3:0] INV_COEF = {4'd9, 4'd13, 4'd11, 4'd14}; // {14,11,13,9}

	logic clk;
	logic reset;
	logic [`AES_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [`AES_DATA_W-1:0] wdata;
	logic [`AES_DATA_W/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`AES_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [`AES_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	int seed = 32;
	int cycle = 0; // posedges since time 0
	bit stall_en = 1'b1; // random bready and rready hold off

	aes_lin_top DUT (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	always #4 clk = ~clk; // 8 ns period

	//////////////////////////////////////////////////
	// failure paths
	//////////////////////////////////////////////////
	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "run stopped at first error");
	endtask

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES)
		begin
			$display("timeout, no finish after %0d cycles", cycle);
			abort_run();
		end
	end

	always @(negedge clk)
	begin
		if (DUT.u_ctrl.u_chk.err_count != 0) // bound checker tally
		begin
			$display("a bus handshake or sequencing assertion failed");
			abort_run();
		end
	end

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
		begin
			$display("MISMATCH %s expected %08h actual %08h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_state(input string name, input logic [127:0] exp, input logic [127:0] act);
		for (int c = 0; c < 4; c++)
			check_word(name, exp[32*c +: 32], act[32*c +: 32]); // one word per column
	endtask

	//////////////////////////////////////////////////
	// reference round model
	//////////////////////////////////////////////////
	function automatic logic [7:0] dbl(input logic [7:0] b);
		return b[7] ? ((b << 1) ^ 8'h1b) : (b << 1); // x times b mod 0x11b
	endfunction

	function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [3:0] k);
		logic [7:0] acc;
		logic [7:0] p;
		acc = 8'h00;
		p = a;
		for (int i = 0; i < 4; i++)
		begin
			if (k[i])
				acc ^= p;
			p = dbl(p); // a, 2a, 4a, 8a
		end
		return acc;
	endfunction

	function automatic logic [31:0] mix_word(input logic [31:0] w, input bit inv);
		logic [31:0] o;
		logic [3:0] k;
		o = '0;
		for (int r = 0; r < 4; r++)
		begin
			for (int j = 0; j < 4; j++)
			begin
				k = inv ? INV_COEF[j] : FWD_COEF[j];
				o[8*r +: 8] ^= gf_mul(w[8*((r + j) % 4) +: 8], k); // circulant row r
			end
		end
		return o;
	endfunction

	function automatic logic [127:0] shift_state(input logic [127:0] s, input bit inv);
		logic [127:0] o;
		int src;
		for (int c = 0; c < 4; c++)
		begin
			for (int r = 0; r < 4; r++)
			begin
				src = inv ? (c + 4 - r) % 4 : (c + r) % 4;
				o[32*c + 8*r +: 8] = s[32*src + 8*r +: 8];
			end
		end
		return o;
	endfunction

	function automatic logic [127:0] model_round(input logic [127:0] s, input logic [127:0] k,
		input bit inv, input bit last_rnd);
		logic [127:0] t;
		t = shift_state(s, inv);
		if (inv)
			t ^= k; // key before InvMixColumns
		if (!last_rnd)
		begin
			for (int c = 0; c < 4; c++)
				t[32*c +: 32] = mix_word(t[32*c +: 32], inv);
		end
		if (!inv)
			t ^= k;
		return t;
	endfunction

	//////////////////////////////////////////////////
	// bus tasks, entered and left just after a posedge
	//////////////////////////////////////////////////
	function automatic int stall_cycles();
		return stall_en ? ($unsigned($random(seed)) % 4) : 0;
	endfunction

	task automatic bus_write(input logic [5:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output int acc);
		int wait_n;
		awaddr <= addr;
		wdata <= data;
		wstrb <= strb;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do
			@(negedge clk);
		while (!(awready && wready)); // both channels taken together
		acc = cycle + 1; // accepting edge
		wait_n = stall_cycles();
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		repeat (wait_n) @(posedge clk); // response held off
		bready <= 1'b1;
		do
			@(negedge clk);
		while (!bvalid);
		assert (bresp == 2'b00)
		else
		begin
			$display("write response to %02h was not OKAY", addr);
			abort_run();
		end
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic bus_read(input logic [5:0] addr, output logic [31:0] data, output int acc);
		int wait_n;
		araddr <= addr;
		arvalid <= 1'b1;
		do
			@(negedge clk);
		while (!arready);
		acc = cycle + 1;
		wait_n = stall_cycles();
		@(posedge clk);
		arvalid <= 1'b0;
		repeat (wait_n) @(posedge clk);
		rready <= 1'b1;
		do
			@(negedge clk);
		while (!rvalid);
		data = rdata; // value at the accepting edge
		assert (rresp == 2'b00)
		else
		begin
			$display("read response from %02h was not OKAY", addr);
			abort_run();
		end
		@(posedge clk);
		rready <= 1'b0;
	endtask

	function automatic logic [31:0] ctrl_word(input bit inv, input bit last_rnd);
		logic [31:0] w;
		w = '0;
		w[`AES_CTRL_START] = 1'b1;
		w[`AES_CTRL_DECRYPT] = inv;
		w[`AES_CTRL_LAST] = last_rnd;
		return w;
	endfunction

	task automatic load_operands(input logic [127:0] st, input logic [127:0] key);
		int n;
		for (int c = 0; c < 4; c++)
			bus_write(`AES_REG_STATE0 + 6'(4*c), st[32*c +: 32], 4'hf, n);
		for (int c = 0; c < 4; c++)
			bus_write(`AES_REG_KEY0 + 6'(4*c), key[32*c +: 32], 4'hf, n);
	endtask

	task automatic read_state(output logic [127:0] res);
		int n;
		logic [31:0] w;
		for (int c = 0; c < 4; c++)
		begin
			bus_read(`AES_REG_STATE0 + 6'(4*c), w, n);
			res[32*c +: 32] = w;
		end
	endtask

	task automatic run_round(input logic [127:0] st, input logic [127:0] key,
		input bit inv, input bit last_rnd, output logic [127:0] res);
		logic [31:0] s;
		int n;
		load_operands(st, key);
		bus_write(`AES_REG_CTRL, ctrl_word(inv, last_rnd), 4'h1, n);
		do
			bus_read(`AES_REG_STATUS, s, n); // poll for done
		while (!s[`AES_STAT_DONE]);
		read_state(res);
	endtask

	function automatic logic [127:0] rand_state();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////
	initial
	begin
		logic [127:0] st;
		logic [127:0] key;
		logic [127:0] mid;
		logic [127:0] res;
		logic [31:0] w0;
		logic [31:0] w1;
		logic [31:0] exp_w;
		logic [31:0] rd;
		logic [3:0] strb;
		int h;
		int n;

		clk = 1'b0;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		// byte strobes on state words
		for (int c = 0; c < 4; c++)
		begin
			w0 = $random(seed);
			w1 = $random(seed);
			strb = $random(seed);
			bus_write(`AES_REG_STATE0 + 6'(4*c), w0, 4'hf, n);
			bus_write(`AES_REG_STATE0 + 6'(4*c), w1, strb, n);
			for (int b = 0; b < 4; b++)
				exp_w[8*b +: 8] = strb[b] ? w1[8*b +: 8] : w0[8*b +: 8];
			bus_read(`AES_REG_STATE0 + 6'(4*c), rd, n);
			check_word("state_strobe", exp_w, rd);
		end

		// key words read back
		for (int c = 0; c < 4; c++)
		begin
			w0 = $random(seed);
			bus_write(`AES_REG_KEY0 + 6'(4*c), w0, 4'hf, n);
			bus_read(`AES_REG_KEY0 + 6'(4*c), rd, n);
			check_word("key_readback", w0, rd);
		end

		// column db135345 -> 8e4da1bc, equal columns so ShiftRows does nothing
		run_round({4{32'h455313db}}, '0, 1'b0, 1'b0, res);
		check_state("mix_vector", {4{32'hbca14d8e}}, res);

		for (int i = 0; i < 6; i++)
		begin
			st = rand_state();
			key = rand_state();
			run_round(st, key, 1'b0, 1'b0, res);
			check_state("enc_round", model_round(st, key, 1'b0, 1'b0), res);
		end

		for (int i = 0; i < 6; i++)
		begin
			st = rand_state();
			key = rand_state();
			run_round(st, key, 1'b1, 1'b0, res);
			check_state("dec_round", model_round(st, key, 1'b1, 1'b0), res);
		end

		for (int i = 0; i < 4; i++)
		begin
			st = rand_state();
			key = rand_state();
			run_round(st, key, i[0], 1'b1, res); // both directions
			check_state("last_round", shift_state(st, i[0]) ^ key, res);
		end

		// decrypt round on the output of an encrypt round
		st = rand_state();
		key = rand_state();
		run_round(st, key, 1'b0, 1'b0, mid);
		check_state("enc_dec_chain", model_round(st, key, 1'b0, 1'b0), mid);
		run_round(mid, key, 1'b1, 1'b0, res);
		check_state("enc_dec_chain", model_round(mid, key, 1'b1, 1'b0), res);

		// column-uniform state and key, the pair of rounds is the identity
		w0 = $random(seed);
		w1 = $random(seed);
		st = {4{w0}};
		key = {4{w1}};
		run_round(st, key, 1'b0, 1'b0, mid);
		run_round(mid, key, 1'b1, 1'b0, res);
		check_state("enc_dec_restore", st, res);

		// state write and second start while busy, status timing
		st = rand_state();
		key = rand_state();
		load_operands(st, key);
		stall_en = 1'b0; // both writes must land inside the run
		bus_write(`AES_REG_CTRL, ctrl_word(1'b0, 1'b0), 4'h1, h);
		bus_write(`AES_REG_STATE0 + 6'hc, ~st[127:96], 4'hf, n); // column 3 not yet issued
		bus_write(`AES_REG_CTRL, ctrl_word(1'b1, 1'b1), 4'h1, n);
		do
		begin
			bus_read(`AES_REG_STATUS, rd, n);
			exp_w = '0;
			exp_w[`AES_STAT_BUSY] = (n - h >= 1) && (n - h <= `AES_PASS_CYCLES);
			exp_w[`AES_STAT_DONE] = (n - h > `AES_PASS_CYCLES);
			check_word("status_timing", exp_w, rd);
		end
		while (!rd[`AES_STAT_DONE]);
		stall_en = 1'b1;
		read_state(res);
		check_state("busy_writes", model_round(st, key, 1'b0, 1'b0), res);

		repeat (4) @(posedge clk); // let the checker see the tail
		if (DUT.u_ctrl.u_chk.err_count == 0)
		begin
			$display("Test completed successfully");
			$finish;
		end
		else
		begin
			$display("Test failed");
			$fatal(1, "checker assertions failed");
		end
	end

endmodule

`default_nettype wire

// File: aes_lin_top.f
+incdir+design
design/aes_lin_pkg.sv
design/state_shift_rows.sv
design/word_mix_columns.sv
design/state_store.sv
design/aes_lin_ctrl.sv
design/aes_lin_top.sv
sim/aes_lin_chk.sv
sim/aes_lin_tb.sv
